/* Bender.yml */
package:
  name: exec_unit

sources:
  - mips_isa_pkg.sv
  - exec_cfg_pkg.sv
  - alu.sv
  - instr_decode.sv
  - reg_file.sv
  - clear_counter.sv
  - exec_fsm.sv
  - exec_unit_top.sv
  - target: test
    files:
      - exec_unit_chk.sv
      - tb_exec_unit.sv

/* alu.sv */
module alu #(
    parameter int NB_DATA = 32
) (
    input  logic [NB_DATA-1:0]                  i_data_a,
    input  logic [NB_DATA-1:0]                  i_data_b,
    input  logic [exec_cfg_pkg::NB_ALU_OP-1:0]  i_opcode,
    output logic [NB_DATA-1:0]                  o_result,
    output logic                                o_zero_bit
);

    logic [4:0]         shamt;      // Shift amount from operand A
    logic               a_lt_b;     // Signed compare
    logic [NB_DATA-1:0] result;

    assign shamt  = i_data_a[4:0];
    assign a_lt_b = $signed(i_data_a) < $signed(i_data_b);

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        case (i_opcode)
            // Arithmetic
            exec_cfg_pkg::ALU_ADD:
                result = $signed(i_data_a) + $signed(i_data_b);
            exec_cfg_pkg::ALU_ADDU:
                result = i_data_a + i_data_b;
            exec_cfg_pkg::ALU_SUBU:
                result = $signed(i_data_a) - $signed(i_data_b);

            // Logic and compare
            exec_cfg_pkg::ALU_AND:
                result = i_data_a & i_data_b;
            exec_cfg_pkg::ALU_OR:
                result = i_data_a | i_data_b;
            exec_cfg_pkg::ALU_XOR:
                result = i_data_a ^ i_data_b;
            exec_cfg_pkg::ALU_NOR:
                result = ~(i_data_a | i_data_b);
            exec_cfg_pkg::ALU_SLT:
                result = {{(NB_DATA-1){1'b0}}, a_lt_b};

            // Shifts, B is the value and A the amount
            exec_cfg_pkg::ALU_SLL,
            exec_cfg_pkg::ALU_SLLV:
                result = i_data_b << shamt;
            exec_cfg_pkg::ALU_SRL,
            exec_cfg_pkg::ALU_SRLV:
                result = i_data_b >> shamt;                 // Zero fill
            exec_cfg_pkg::ALU_SRA,
            exec_cfg_pkg::ALU_SRAV:
                result = $signed(i_data_b) >>> shamt;       // Sign fill

            // Low half of B into the upper half
            exec_cfg_pkg::ALU_SHIFTLUI:
                result = {i_data_b[15:0], {(NB_DATA-16){1'b0}}};

            default:
                result = {NB_DATA{1'b1}};
        endcase
    end

    assign o_result   = result;
    assign o_zero_bit = ~|result;

endmodule

/* clear_counter.sv */
module clear_counter (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_start,
    output logic [exec_cfg_pkg::NB_REG_ADDR-1:0]  o_addr,
    output logic                                  o_clearing,
    output logic                                  o_done
);

    localparam logic [exec_cfg_pkg::NB_REG_ADDR-1:0] LAST_ADDR =
        exec_cfg_pkg::NB_REG_ADDR'(exec_cfg_pkg::NUM_REGS - 1);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_addr     <= '0;
            o_clearing <= 1'b0;
            o_done     <= 1'b0;
        end else if (o_clearing) begin
            if (o_addr == LAST_ADDR) begin          // Sweep ends after the last register
                o_clearing <= 1'b0;
                o_done     <= 1'b1;
            end else begin
                o_addr <= o_addr + 1'b1;
            end
        end else if (i_start && !o_done) begin
            o_addr     <= '0;
            o_clearing <= 1'b1;
        end
    end

endmodule

/* exec_cfg_pkg.sv */
package exec_cfg_pkg;

    // ------------------------------
    // Datapath sizes
    // ------------------------------
    localparam int NB_DATA     = 32;
    localparam int NB_REG_ADDR = 5;
    localparam int NUM_REGS    = 32;
    localparam int NB_ALU_OP   = 6;

    // ------------------------------
    // ALU operation codes
    // ------------------------------
    localparam logic [NB_ALU_OP-1:0] ALU_SLL      = 6'b000000;
    localparam logic [NB_ALU_OP-1:0] ALU_SRL      = 6'b000010;
    localparam logic [NB_ALU_OP-1:0] ALU_SRA      = 6'b000011;
    localparam logic [NB_ALU_OP-1:0] ALU_SLLV     = 6'b000100;
    localparam logic [NB_ALU_OP-1:0] ALU_SRLV     = 6'b000110;
    localparam logic [NB_ALU_OP-1:0] ALU_SRAV     = 6'b000111;
    localparam logic [NB_ALU_OP-1:0] ALU_ADD      = 6'b110001; // Not the funct value
    localparam logic [NB_ALU_OP-1:0] ALU_ADDU     = 6'b100001;
    localparam logic [NB_ALU_OP-1:0] ALU_SUBU     = 6'b100011;
    localparam logic [NB_ALU_OP-1:0] ALU_AND      = 6'b100100;
    localparam logic [NB_ALU_OP-1:0] ALU_OR       = 6'b100101;
    localparam logic [NB_ALU_OP-1:0] ALU_XOR      = 6'b100110;
    localparam logic [NB_ALU_OP-1:0] ALU_NOR      = 6'b100111;
    localparam logic [NB_ALU_OP-1:0] ALU_SLT      = 6'b101010;
    localparam logic [NB_ALU_OP-1:0] ALU_SHIFTLUI = 6'b101011;

    // No ALU case matches this code, so it falls to the all-ones default
    localparam logic [NB_ALU_OP-1:0] ALU_ILLEGAL  = 6'b111111;

    localparam logic [NB_DATA-1:0]   ILLEGAL_RESULT = {NB_DATA{1'b1}};

endpackage

/* exec_fsm.sv */
module exec_fsm (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_req,
    input  logic i_clear_done,
    output logic o_clear_start,
    output logic o_latch,
    output logic o_read,
    output logic o_exec,
    output logic o_ack
);

    typedef enum logic [2:0] {
        CLEAR,      // Register sweep after reset
        IDLE,
        READ,       // Register file read
        EXEC,       // ALU result and write back
        ACK,
        RELEASE     // Requester still holds i_req
    } state_t;

    state_t state;
    state_t state_next;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= CLEAR;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            CLEAR: begin
                if (i_clear_done) begin
                    state_next = IDLE;
                end
            end
            IDLE: begin
                if (i_req) begin
                    state_next = READ;
                end
            end
            READ:    state_next = EXEC;
            EXEC:    state_next = ACK;
            ACK: begin
                // Ack drops on the first edge that sees the request gone
                state_next = i_req ? RELEASE : IDLE;
            end
            RELEASE: begin
                if (!i_req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = CLEAR;
        endcase
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign o_clear_start = (state == CLEAR);
    assign o_latch       = (state == IDLE) && i_req;    // Instruction taken on this edge
    assign o_read        = (state == READ);
    assign o_exec        = (state == EXEC);
    assign o_ack         = (state == ACK) || (state == RELEASE);

endmodule

/* exec_unit_chk.sv */
module exec_unit_chk (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_req,
    input  logic                              i_latch,
    input  logic                              i_ack,
    input  logic [exec_cfg_pkg::NB_DATA-1:0]  i_result,
    input  logic                              i_zero
);

    int unsigned fail_count = 0;        // Failed assertions so far

    // ------------------------------
    // Handshake rules
    // ------------------------------
    ack_low_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !i_ack)
        else begin
            $error("o_ack high while reset is applied");
            fail_count++;
        end

    // Request held on the edge that raised ack
    ack_rise_with_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> $past(i_req))
        else begin
            $error("o_ack rose without a pending request");
            fail_count++;
        end

    // Requester must have let go first
    ack_fall_after_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_ack) |-> !$past(i_req))
        else begin
            $error("o_ack fell while the request was still held");
            fail_count++;
        end

    result_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ack && $past(i_ack) |-> $stable(i_result) && $stable(i_zero))
        else begin
            $error("result changed while o_ack was high");
            fail_count++;
        end

    // Latch edge, read, execute, then ack
    ack_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_latch |-> ##3 $rose(i_ack))
        else begin
            $error("o_ack did not rise 3 cycles after the request was taken");
            fail_count++;
        end

endmodule

/* exec_unit_top.sv */
module exec_unit_top (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_req,
    input  logic [$bits(mips_isa_pkg::instr_u)-1:0] i_instr,
    output logic                                    o_ack,
    output logic [exec_cfg_pkg::NB_DATA-1:0]        o_result,
    output logic                                    o_zero
);

    localparam int NB_DATA = exec_cfg_pkg::NB_DATA;
    localparam int NB_ADDR = exec_cfg_pkg::NB_REG_ADDR;

    // Control strobes
    logic latch, read, exec, clear_start, clear_done, clearing;
    logic [NB_ADDR-1:0] clr_addr;

    // Decoded fields
    mips_isa_pkg::instr_u          instr_q;
    logic [NB_ADDR-1:0]            rs_addr, rt_addr, dst_addr;
    logic                          a_from_shamt, b_from_imm, dec_wr_en;
    logic [NB_DATA-1:0]            imm_ext;
    logic [exec_cfg_pkg::NB_ALU_OP-1:0] alu_op;

    // Datapath
    logic [NB_DATA-1:0] rs_data, rt_data, alu_a, alu_b, alu_result, wr_data;
    logic               alu_zero, wr_en;
    logic [NB_ADDR-1:0] wr_addr;

    exec_fsm u_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req         (i_req),
        .i_clear_done  (clear_done),
        .o_clear_start (clear_start),
        .o_latch       (latch),
        .o_read        (read),
        .o_exec        (exec),
        .o_ack         (o_ack)
    );

    clear_counter u_clear (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (clear_start),
        .o_addr     (clr_addr),
        .o_clearing (clearing),
        .o_done     (clear_done)
    );

    always_ff @(posedge i_clk) begin
        if (latch) begin
            instr_q <= i_instr;             // Held for the whole transaction
        end
    end

    instr_decode u_decode (
        .i_instr        (instr_q),
        .o_rs_addr      (rs_addr),
        .o_rt_addr      (rt_addr),
        .o_dst_addr     (dst_addr),
        .o_a_from_shamt (a_from_shamt),
        .o_b_from_imm   (b_from_imm),
        .o_wr_en        (dec_wr_en),
        .o_imm_ext      (imm_ext),
        .o_alu_op       (alu_op)
    );

    // ------------------------------
    // Write port and operand muxes
    // ------------------------------
    assign wr_en   = clearing || (exec && dec_wr_en);
    assign wr_addr = clearing ? clr_addr : dst_addr;
    assign wr_data = clearing ? '0 : alu_result;

    assign alu_a = a_from_shamt ? {{(NB_DATA-5){1'b0}}, instr_q.r.shamt} : rs_data;
    assign alu_b = b_from_imm ? imm_ext : rt_data;

    reg_file u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rd_en   (read),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    alu #(
        .NB_DATA (NB_DATA)
    ) u_alu (
        .i_data_a   (alu_a),
        .i_data_b   (alu_b),
        .i_opcode   (alu_op),
        .o_result   (alu_result),
        .o_zero_bit (alu_zero)
    );

    // Result stays put while ack is up
    always_ff @(posedge i_clk) begin
        if (exec) begin
            o_result <= alu_result;
            o_zero   <= alu_zero;
        end
    end

endmodule

/* flist.f */
mips_isa_pkg.sv
exec_cfg_pkg.sv
alu.sv
instr_decode.sv
reg_file.sv
clear_counter.sv
exec_fsm.sv
exec_unit_top.sv
exec_unit_chk.sv
tb_exec_unit.sv

/* instr_decode.sv */
module instr_decode (
    input  logic [$bits(mips_isa_pkg::instr_u)-1:0]   i_instr,
    output logic [exec_cfg_pkg::NB_REG_ADDR-1:0]      o_rs_addr,
    output logic [exec_cfg_pkg::NB_REG_ADDR-1:0]      o_rt_addr,
    output logic [exec_cfg_pkg::NB_REG_ADDR-1:0]      o_dst_addr,
    output logic                                      o_a_from_shamt,
    output logic                                      o_b_from_imm,
    output logic                                      o_wr_en,
    output logic [exec_cfg_pkg::NB_DATA-1:0]          o_imm_ext,
    output logic [exec_cfg_pkg::NB_ALU_OP-1:0]        o_alu_op
);

    mips_isa_pkg::instr_u instr;
    logic                 zero_ext;     // ANDI, ORI, XORI

    assign instr     = i_instr;
    assign o_rs_addr = instr.r.rs;      // Same bits in both views
    assign o_rt_addr = instr.r.rt;

    assign o_imm_ext = zero_ext ?
        {{(exec_cfg_pkg::NB_DATA-16){1'b0}}, instr.i.imm} :
        {{(exec_cfg_pkg::NB_DATA-16){instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        o_alu_op       = exec_cfg_pkg::ALU_ILLEGAL;
        o_wr_en        = 1'b1;
        o_a_from_shamt = 1'b0;
        o_b_from_imm   = 1'b0;
        zero_ext       = 1'b0;
        o_dst_addr     = instr.i.rt;

        if (instr.r.opcode == mips_isa_pkg::OP_RTYPE) begin
            o_dst_addr = instr.r.rd;
            case (instr.r.funct)
                mips_isa_pkg::FN_SLL: begin
                    o_alu_op       = exec_cfg_pkg::ALU_SLL;
                    o_a_from_shamt = 1'b1;
                end
                mips_isa_pkg::FN_SRL: begin
                    o_alu_op       = exec_cfg_pkg::ALU_SRL;
                    o_a_from_shamt = 1'b1;
                end
                mips_isa_pkg::FN_SRA: begin
                    o_alu_op       = exec_cfg_pkg::ALU_SRA;
                    o_a_from_shamt = 1'b1;
                end
                mips_isa_pkg::FN_SLLV: o_alu_op = exec_cfg_pkg::ALU_SLLV;
                mips_isa_pkg::FN_SRLV: o_alu_op = exec_cfg_pkg::ALU_SRLV;
                mips_isa_pkg::FN_SRAV: o_alu_op = exec_cfg_pkg::ALU_SRAV;
                mips_isa_pkg::FN_ADD:  o_alu_op = exec_cfg_pkg::ALU_ADD;
                mips_isa_pkg::FN_ADDU: o_alu_op = exec_cfg_pkg::ALU_ADDU;
                mips_isa_pkg::FN_SUBU: o_alu_op = exec_cfg_pkg::ALU_SUBU;
                mips_isa_pkg::FN_AND:  o_alu_op = exec_cfg_pkg::ALU_AND;
                mips_isa_pkg::FN_OR:   o_alu_op = exec_cfg_pkg::ALU_OR;
                mips_isa_pkg::FN_XOR:  o_alu_op = exec_cfg_pkg::ALU_XOR;
                mips_isa_pkg::FN_NOR:  o_alu_op = exec_cfg_pkg::ALU_NOR;
                mips_isa_pkg::FN_SLT:  o_alu_op = exec_cfg_pkg::ALU_SLT;
                default:               o_wr_en  = 1'b0;    // Unknown funct
            endcase
        end else begin
            o_b_from_imm = 1'b1;
            case (instr.i.opcode)
                mips_isa_pkg::OP_ADDI:  o_alu_op = exec_cfg_pkg::ALU_ADD;
                mips_isa_pkg::OP_ADDIU: o_alu_op = exec_cfg_pkg::ALU_ADDU;
                mips_isa_pkg::OP_SLTI:  o_alu_op = exec_cfg_pkg::ALU_SLT;
                mips_isa_pkg::OP_LUI:   o_alu_op = exec_cfg_pkg::ALU_SHIFTLUI;
                mips_isa_pkg::OP_ANDI: begin
                    o_alu_op = exec_cfg_pkg::ALU_AND;
                    zero_ext = 1'b1;
                end
                mips_isa_pkg::OP_ORI: begin
                    o_alu_op = exec_cfg_pkg::ALU_OR;
                    zero_ext = 1'b1;
                end
                mips_isa_pkg::OP_XORI: begin
                    o_alu_op = exec_cfg_pkg::ALU_XOR;
                    zero_ext = 1'b1;
                end
                default: o_wr_en = 1'b0;                   // Unknown opcode
            endcase
        end
    end

endmodule

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // ------------------------------
    // Primary opcodes
    // ------------------------------
    localparam logic [5:0] OP_RTYPE = 6'b000000; // Operation given by funct
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_ANDI  = 6'b001100; // Zero-extended immediate
    localparam logic [5:0] OP_ORI   = 6'b001101; // Zero-extended immediate
    localparam logic [5:0] OP_XORI  = 6'b001110; // Zero-extended immediate
    localparam logic [5:0] OP_LUI   = 6'b001111;

    // ------------------------------
    // R-type funct values
    // ------------------------------
    localparam logic [5:0] FN_SLL   = 6'b000000; // Shift by shamt
    localparam logic [5:0] FN_SRL   = 6'b000010;
    localparam logic [5:0] FN_SRA   = 6'b000011;
    localparam logic [5:0] FN_SLLV  = 6'b000100; // Shift by rs
    localparam logic [5:0] FN_SRLV  = 6'b000110;
    localparam logic [5:0] FN_SRAV  = 6'b000111;
    localparam logic [5:0] FN_ADD   = 6'b100000;
    localparam logic [5:0] FN_ADDU  = 6'b100001;
    localparam logic [5:0] FN_SUBU  = 6'b100011;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_XOR   = 6'b100110;
    localparam logic [5:0] FN_NOR   = 6'b100111;
    localparam logic [5:0] FN_SLT   = 6'b101010;

    // Register-register format
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // Immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same 32-bit word, opcode picks the view
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

/* reg_file.sv */
module reg_file (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,
    input  logic                                  i_rd_en,
    input  logic [exec_cfg_pkg::NB_REG_ADDR-1:0]  i_rs_addr,
    input  logic [exec_cfg_pkg::NB_REG_ADDR-1:0]  i_rt_addr,
    input  logic                                  i_wr_en,
    input  logic [exec_cfg_pkg::NB_REG_ADDR-1:0]  i_wr_addr,
    input  logic [exec_cfg_pkg::NB_DATA-1:0]      i_wr_data,
    output logic [exec_cfg_pkg::NB_DATA-1:0]      o_rs_data,
    output logic [exec_cfg_pkg::NB_DATA-1:0]      o_rt_data
);

    logic [exec_cfg_pkg::NB_DATA-1:0] regs [exec_cfg_pkg::NUM_REGS];

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr_en && (i_wr_addr != '0)) begin     // Register 0 is never written
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // ------------------------------
    // Read ports
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_rs_data <= '0;
            o_rt_data <= '0;
        end else if (i_rd_en) begin
            // Register 0 reads zero whatever the array holds
            if (i_rs_addr == '0) begin
                o_rs_data <= '0;
            end else begin
                o_rs_data <= regs[i_rs_addr];
            end
            if (i_rt_addr == '0) begin
                o_rt_data <= '0;
            end else begin
                o_rt_data <= regs[i_rt_addr];
            end
        end
    end

endmodule

/* tb_exec_unit.sv */
module tb_exec_unit;

    localparam int N_CLEAR = 8;
    localparam int N_RAND  = 40;
    localparam int N_SHIFT = 30;
    localparam int N_ILL   = 10;
    localparam int N_HOLD  = 10;
    localparam int NUM_TXN = N_CLEAR + 3 * exec_cfg_pkg::NUM_REGS + 2 * N_RAND + N_SHIFT
                             + 2 * N_ILL + N_HOLD;
    localparam int MAX_CYCLES = 32 + NUM_TXN * 12 + 100;

    localparam logic [5:0] ARITH_FN [8] = '{mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU,
        mips_isa_pkg::FN_SUBU, mips_isa_pkg::FN_AND, mips_isa_pkg::FN_OR,
        mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_NOR, mips_isa_pkg::FN_SLT};
    localparam logic [5:0] SHIFT_FN [6] = '{mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL,
        mips_isa_pkg::FN_SRA, mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV,
        mips_isa_pkg::FN_SRAV};
    localparam logic [5:0] IMM_OP [6] = '{mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU,
        mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI,
        mips_isa_pkg::OP_SLTI};

    logic        i_clk, i_rst_n, i_req, o_ack, o_zero;
    logic [31:0] i_instr, o_result;
    logic [31:0] model_regs [32];       // Expected register contents
    int unsigned cycles = 0;

    exec_unit_top UUT (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (i_req),
        .i_instr  (i_instr),
        .o_ack    (o_ack),
        .o_result (o_result),
        .o_zero   (o_zero)
    );

    bind exec_unit_top exec_unit_chk u_chk (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_req (i_req), .i_latch (latch),
        .i_ack (o_ack), .i_result (o_result), .i_zero (o_zero)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles without finishing", cycles));
        end
    end

    always @(negedge i_clk) begin
        if (UUT.u_chk.fail_count != 0) begin
            abort_run("A handshake assertion on the DUT failed");
        end
    end

    function automatic logic [4:0] rand_reg();
        return 5'($urandom);
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] shamt);
        mips_isa_pkg::instr_u w;
        w.r = '{mips_isa_pkg::OP_RTYPE, rs, rt, rd, shamt, fn};
        return w;
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        mips_isa_pkg::instr_u w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic bit legal_funct(input logic [5:0] fn);
        return fn inside {ARITH_FN, SHIFT_FN};
    endfunction

    function automatic bit legal_op(input logic [5:0] op);
        return op inside {IMM_OP, mips_isa_pkg::OP_LUI};
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_exec(input logic [31:0] word, output logic [31:0] res,
                              output logic wr, output logic [4:0] dst);
        mips_isa_pkg::instr_u w;
        logic [31:0] a, b, imm_s, imm_z;
        w     = word;
        a     = model_regs[w.r.rs];
        b     = model_regs[w.r.rt];
        imm_s = {{16{w.i.imm[15]}}, w.i.imm};
        imm_z = {16'h0000, w.i.imm};
        res   = exec_cfg_pkg::ILLEGAL_RESULT;
        wr    = legal_op(w.i.opcode) || (w.r.opcode == mips_isa_pkg::OP_RTYPE
                                         && legal_funct(w.r.funct));
        dst   = (w.r.opcode == mips_isa_pkg::OP_RTYPE) ? w.r.rd : w.i.rt;
        if (w.r.opcode == mips_isa_pkg::OP_RTYPE) begin
            case (w.r.funct)
                mips_isa_pkg::FN_SLL:  res = b << w.r.shamt;
                mips_isa_pkg::FN_SRL:  res = b >> w.r.shamt;
                mips_isa_pkg::FN_SRA:  res = $signed(b) >>> w.r.shamt;
                mips_isa_pkg::FN_SLLV: res = b << a[4:0];
                mips_isa_pkg::FN_SRLV: res = b >> a[4:0];
                mips_isa_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                mips_isa_pkg::FN_ADD,
                mips_isa_pkg::FN_ADDU: res = a + b;     // No overflow trap
                mips_isa_pkg::FN_SUBU: res = a - b;
                mips_isa_pkg::FN_AND:  res = a & b;
                mips_isa_pkg::FN_OR:   res = a | b;
                mips_isa_pkg::FN_XOR:  res = a ^ b;
                mips_isa_pkg::FN_NOR:  res = ~(a | b);
                mips_isa_pkg::FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                default:               res = exec_cfg_pkg::ILLEGAL_RESULT;
            endcase
        end else begin
            case (w.i.opcode)
                mips_isa_pkg::OP_ADDI,
                mips_isa_pkg::OP_ADDIU: res = a + imm_s;
                mips_isa_pkg::OP_ANDI:  res = a & imm_z;
                mips_isa_pkg::OP_ORI:   res = a | imm_z;
                mips_isa_pkg::OP_XORI:  res = a ^ imm_z;
                mips_isa_pkg::OP_SLTI:  res = {31'd0, $signed(a) < $signed(imm_s)};
                mips_isa_pkg::OP_LUI:   res = {w.i.imm, 16'h0000};
                default:                res = exec_cfg_pkg::ILLEGAL_RESULT;
            endcase
        end
    endtask

    task automatic check_result(input logic [31:0] exp_res);
        assert (o_result === exp_res) else abort_run($sformatf(
            "CHECK FAILED o_result expected %h got %h", exp_res, o_result));
        assert (o_zero === (exp_res == '0)) else abort_run($sformatf(
            "CHECK FAILED o_zero expected %h got %h", exp_res == '0, o_zero));
    endtask

    // One four-phase transaction, holding the request for extra cycles
    task automatic run_txn(input logic [31:0] word, input int hold);
        logic [31:0] exp_res;
        logic        exp_wr;
        logic [4:0]  exp_dst;
        model_exec(word, exp_res, exp_wr, exp_dst);
        @(negedge i_clk);
        i_req   = 1'b1;
        i_instr = word;
        do @(negedge i_clk); while (!o_ack);
        check_result(exp_res);
        repeat (hold) begin
            @(negedge i_clk);
            check_result(exp_res);              // Held under back-pressure
        end
        i_req = 1'b0;
        do @(negedge i_clk); while (o_ack);
        if (exp_wr && exp_dst != 5'd0) begin
            model_regs[exp_dst] = exp_res;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        mips_isa_pkg::instr_u w;
        logic [4:0]  rs, rt;
        logic [5:0]  code;
        logic [31:0] word;
        void'($urandom(36));
        i_rst_n = 1'b0;
        i_req   = 1'b0;
        i_instr = '0;
        foreach (model_regs[k]) begin
            model_regs[k] = '0;
        end
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;

        repeat (N_CLEAR) begin                  // First ones wait out the sweep
            run_txn(r_word(mips_isa_pkg::FN_OR, rand_reg(), rand_reg(), rand_reg(), 5'd0), 0);
        end

        for (int r = 0; r < 32; r++) begin      // Register 0 included
            word = $urandom;
            run_txn(i_word(mips_isa_pkg::OP_LUI, rand_reg(), 5'(r), word[31:16]), 0);
            run_txn(i_word(mips_isa_pkg::OP_ORI, 5'(r), 5'(r), word[15:0]), 0);
        end
        for (int r = 0; r < 32; r++) begin
            run_txn(r_word(mips_isa_pkg::FN_OR, 5'(r), 5'd0, 5'd0, 5'd0), 0);
        end

        repeat (N_RAND) begin
            rs = rand_reg();
            rt = ($urandom % 8 == 0) ? rs : rand_reg();     // Equal operands hit zero
            run_txn(r_word(ARITH_FN[$urandom % 8], rs, rt, rand_reg(), 5'd0), 0);
            run_txn(i_word(IMM_OP[$urandom % 6], rand_reg(), rand_reg(), 16'($urandom)), 0);
        end

        repeat (N_SHIFT) begin
            word = r_word(SHIFT_FN[$urandom % 6], rand_reg(), rand_reg(), rand_reg(),
                          5'($urandom));
            run_txn(word, 0);
        end

        repeat (N_ILL) begin
            if ($urandom % 2) begin
                do code = 6'($urandom); while (legal_funct(code));
                w  = r_word(code, rand_reg(), rand_reg(), rand_reg(), 5'($urandom));
                rs = w.r.rd;
            end else begin
                do code = 6'($urandom); while (code == mips_isa_pkg::OP_RTYPE || legal_op(code));
                w  = i_word(code, rand_reg(), rand_reg(), 16'($urandom));
                rs = w.i.rt;
            end
            run_txn(w, 0);
            run_txn(r_word(mips_isa_pkg::FN_OR, rs, 5'd0, 5'd0, 5'd0), 0);  // Read back
        end

        repeat (N_HOLD) begin
            word = r_word(ARITH_FN[$urandom % 8], rand_reg(), rand_reg(), rand_reg(), 5'd0);
            run_txn(word, 1 + $urandom % 5);
        end

        @(negedge i_clk);
        if (UUT.u_chk.fail_count != 0) begin
            abort_run("A handshake assertion on the DUT failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
